// File: hw/luma_cost_pkg.sv
/*
 * Shared widths and types for the luma residual cost subsystem.
 * Every RTL module and the testbench refer to these definitions, so the
 * coefficient, energy and cost widths are set in this one place.
 * The energy and cost widths are sized so that a full block of
 * maximum-magnitude coefficients cannot overflow.
 */

package luma_cost_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int COEF_W   = 16;
    localparam int ROW_LEN  = 16;
    localparam int MAX_ROWS = 16;

    // A square of a 16-bit signed value is at most 2^30
    localparam int SQ_W     = 2 * COEF_W - 1;
    // Seventeen squares per row need five extra bits
    localparam int ENERGY_W = SQ_W + 5;
    localparam int COST_W   = ENERGY_W + $clog2(MAX_ROWS);
    localparam int CAND_W   = 4;
    localparam int ROW_IDX_W = $clog2(MAX_ROWS);

    // ------------------------------
    // Types
    // ------------------------------
    typedef logic signed [COEF_W-1:0]    coef_t;

    // Coefficient 0 sits in the low 16 bits
    typedef coef_t [ROW_LEN-1:0]         ac_row_t;

    typedef logic [SQ_W-1:0]             sq_t;
    typedef logic [ENERGY_W-1:0]         row_energy_t;
    typedef logic [COST_W-1:0]           cost_t;
    typedef logic [CAND_W-1:0]           cand_t;
    typedef logic [ROW_IDX_W-1:0]        row_idx_t;

endpackage

// File: hw/coef_row_buffer.sv
/*
 * Row-addressed register store for one block of coefficient data.
 * One synchronous write port loads an entry from the host; the read
 * port is combinational so the sequencer can fetch a new row every
 * cycle. The payload type is a parameter, so the same store holds the
 * AC rows in one instance and the DC coefficients in another.
 */

`timescale 1ns/10ps

module coef_row_buffer #(
    parameter int  DEPTH   = 16,
    parameter type entry_t = luma_cost_pkg::coef_t
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  luma_cost_pkg::row_idx_t wr_addr,
    input  entry_t                  wr_data,
    input  luma_cost_pkg::row_idx_t rd_addr,
    output entry_t                  rd_data
);

    entry_t mem [DEPTH];

    // ------------------------------
    // Write port
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en && (int'(wr_addr) < DEPTH)) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------
    // Out-of-range rows read as zero
    always_comb begin
        if (int'(rd_addr) < DEPTH) begin
            rd_data = mem[rd_addr];
        end else begin
            rd_data = '0;
        end
    end

endmodule

// File: hw/row_energy.sv
/*
 * Energy of one coefficient row.
 * Squares the sixteen signed AC coefficients and the DC coefficient,
 * adds the AC squares in a balanced tree, adds the DC square at the
 * root and registers the result. Latency is one cycle; energy_vld
 * follows in_vld by one cycle.
 */

`timescale 1ns/10ps

module row_energy (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_vld,
    input  luma_cost_pkg::ac_row_t     ac,
    input  luma_cost_pkg::coef_t       dc,
    output luma_cost_pkg::row_energy_t energy,
    output logic                       energy_vld
);

    import luma_cost_pkg::*;

    // Heap-ordered tree, nodes 0..ROW_LEN-2 are adders and the rest are leaves
    row_energy_t               tree [2*ROW_LEN-1];
    logic signed [2*COEF_W-1:0] dc_prod;
    sq_t                       dc_sq;
    row_energy_t               sum_all;

    // ------------------------------
    // Squares
    // ------------------------------
    for (genvar i = 0; i < ROW_LEN; i++) begin : g_sq
        coef_t                      c;
        logic signed [2*COEF_W-1:0] prod;

        assign c    = ac[i];
        assign prod = c * c;
        assign tree[ROW_LEN-1+i] = row_energy_t'(sq_t'(prod));
    end

    assign dc_prod = dc * dc;
    assign dc_sq   = sq_t'(dc_prod);

    // Adder tree
    for (genvar n = 0; n < ROW_LEN - 1; n++) begin : g_add
        assign tree[n] = tree[2*n+1] + tree[2*n+2];
    end

    assign sum_all = tree[0] + row_energy_t'(dc_sq);

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            energy_vld <= 1'b0;
        end else begin
            energy_vld <= in_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (in_vld) begin
            energy <= sum_all;
        end
    end

endmodule

// File: hw/block_cost_accum.sv
/*
 * Block cost sequencer.
 * An accepted start latches the candidate, clears the cost and walks
 * rd_row from 0 to ROWS-1, one row per cycle. Each valid row energy
 * coming back from the energy stage is added into the cost. When the
 * last energy has been added, done pulses for one cycle and the cost
 * stays valid until the next accepted start. A start while busy is
 * ignored.
 */

`timescale 1ns/10ps

module block_cost_accum #(
    parameter int ROWS = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  luma_cost_pkg::cand_t       start_cand,
    output logic                       busy,
    output luma_cost_pkg::row_idx_t    rd_row,
    output logic                       rd_vld,
    input  luma_cost_pkg::row_energy_t energy,
    input  logic                       energy_vld,
    output luma_cost_pkg::cost_t       cost,
    output luma_cost_pkg::cand_t       cost_cand,
    output logic                       done
);

    import luma_cost_pkg::*;

    localparam row_idx_t LAST_ROW = row_idx_t'(ROWS - 1);

    logic accept;
    logic last_energy;

    assign accept = start && !busy;
    // Reads are over and the final energy is at the adder
    assign last_energy = busy && !rd_vld && energy_vld;

    // ------------------------------
    // Row walk
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            rd_row <= '0;
            rd_vld <= 1'b0;
        end else if (accept) begin
            busy   <= 1'b1;
            rd_row <= '0;
            rd_vld <= 1'b1;
        end else begin
            if (rd_vld) begin
                if (rd_row == LAST_ROW) begin
                    rd_vld <= 1'b0;
                end else begin
                    rd_row <= rd_row + 1'b1;
                end
            end
            if (last_energy) begin
                busy <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Accumulate and finish
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cost      <= '0;
            cost_cand <= '0;
            done      <= 1'b0;
        end else begin
            done <= last_energy;
            if (accept) begin
                cost      <= '0;
                cost_cand <= start_cand;
            end else if (busy && energy_vld) begin
                cost <= cost + cost_t'(energy);
            end
        end
    end

endmodule

// File: hw/best_cost_select.sv
/*
 * Keeps the lowest block cost seen for the current block and the
 * candidate that produced it. A result is taken on done when no best
 * is held yet or when it is strictly lower, so a tie keeps the earlier
 * candidate. new_block drops the held best; a done in the same cycle
 * becomes the first best of the new block.
 */

`timescale 1ns/10ps

module best_cost_select (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 new_block,
    input  logic                 done,
    input  luma_cost_pkg::cost_t cost,
    input  luma_cost_pkg::cand_t cost_cand,
    output luma_cost_pkg::cost_t best_cost,
    output luma_cost_pkg::cand_t best_id,
    output logic                 best_valid
);

    logic take;

    // Strict compare keeps the earlier id on a tie
    assign take = done && (new_block || !best_valid || (cost < best_cost));

    // ------------------------------
    // Best holder
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_cost  <= '0;
            best_id    <= '0;
            best_valid <= 1'b0;
        end else if (take) begin
            best_cost  <= cost;
            best_id    <= cost_cand;
            best_valid <= 1'b1;
        end else if (new_block) begin
            best_valid <= 1'b0;
        end
    end

endmodule

// File: hw/luma_cost_unit.sv
/*
 * Luma residual cost unit for one 16-column block.
 * The host writes the block row by row into the AC and DC buffers,
 * then pulses start with a candidate number. The sequencer reads one
 * row per cycle, the energy stage squares and sums each row, and the
 * block cost comes out with a done pulse ROWS+2 cycles after start.
 * The selector tracks the lowest cost until new_block.
 */

`timescale 1ns/10ps

module luma_cost_unit #(
    parameter int ROWS = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    row_wr,
    input  luma_cost_pkg::row_idx_t wr_row,
    input  luma_cost_pkg::ac_row_t  wr_ac,
    input  luma_cost_pkg::coef_t    wr_dc,
    input  logic                    start,
    input  luma_cost_pkg::cand_t    cand_id,
    input  logic                    new_block,
    output logic                    busy,
    output luma_cost_pkg::cost_t    cost,
    output logic                    done,
    output luma_cost_pkg::cost_t    best_cost,
    output luma_cost_pkg::cand_t    best_id,
    output logic                    best_valid
);

    import luma_cost_pkg::*;

    row_idx_t    rd_row;
    logic        rd_vld;
    ac_row_t     rd_ac;
    coef_t       rd_dc;
    row_energy_t energy;
    logic        energy_vld;
    cand_t       cost_cand;

    // ------------------------------
    // Coefficient storage
    // ------------------------------
    coef_row_buffer #(
        .DEPTH   (ROWS),
        .entry_t (ac_row_t)
    ) u_ac_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (row_wr),
        .wr_addr (wr_row),
        .wr_data (wr_ac),
        .rd_addr (rd_row),
        .rd_data (rd_ac)
    );

    coef_row_buffer #(
        .DEPTH   (ROWS),
        .entry_t (coef_t)
    ) u_dc_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (row_wr),
        .wr_addr (wr_row),
        .wr_data (wr_dc),
        .rd_addr (rd_row),
        .rd_data (rd_dc)
    );

    // ------------------------------
    // Cost pipeline
    // ------------------------------
    row_energy u_energy (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_vld     (rd_vld),
        .ac         (rd_ac),
        .dc         (rd_dc),
        .energy     (energy),
        .energy_vld (energy_vld)
    );

    block_cost_accum #(
        .ROWS (ROWS)
    ) u_accum (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .start_cand (cand_id),
        .busy       (busy),
        .rd_row     (rd_row),
        .rd_vld     (rd_vld),
        .energy     (energy),
        .energy_vld (energy_vld),
        .cost       (cost),
        .cost_cand  (cost_cand),
        .done       (done)
    );

    // Mode decision
    best_cost_select u_select (
        .clk        (clk),
        .rst_n      (rst_n),
        .new_block  (new_block),
        .done       (done),
        .cost       (cost),
        .cost_cand  (cost_cand),
        .best_cost  (best_cost),
        .best_id    (best_id),
        .best_valid (best_valid)
    );

endmodule

// File: verification/luma_cost_properties.sv
/*
 * Concurrent checks on the block cost sequencer, bound into every
 * block_cost_accum instance. Covers the shape of the done pulse and
 * the row address range and order during a pass.
 */

`timescale 1ns/10ps

module luma_cost_properties #(
    parameter int ROWS = 16
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    busy,
    input luma_cost_pkg::row_idx_t rd_row,
    input logic                    done
);

    // Single-cycle done
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !$past(done))
        else $error("done high on two consecutive cycles");

    a_done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(busy))
        else $error("done without busy in the cycle before");

    // Row address only climbs within a pass and never wraps past the last row
    a_row_range: assert property (@(posedge clk) disable iff (!rst_n)
        (busy && $past(busy)) |-> ((rd_row >= $past(rd_row)) && (int'(rd_row) < ROWS)))
        else $error("rd_row out of range or wrapped while busy");

endmodule

bind block_cost_accum luma_cost_properties #(
    .ROWS (ROWS)
) u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .busy   (busy),
    .rd_row (rd_row),
    .done   (done)
);

// File: verification/luma_cost_unit_tb.sv
/*
 * Testbench for the luma cost unit.
 * Applies a table of coefficient blocks, one cost pass per entry, and
 * checks the block cost, the done timing and the best-cost selector
 * against a software sum-of-squares model.
 */

`timescale 1ns/10ps

module luma_cost_unit_tb;

    import luma_cost_pkg::*;

    localparam int ROWS    = 16;
    localparam int N_CASES = 9;
    localparam int TIMEOUT = 200;

    // Pattern kinds
    localparam int K_RAND   = 0;
    localparam int K_MIN    = 1;
    localparam int K_ZERO   = 2;
    localparam int K_SCALED = 3;

    typedef struct packed {
        int kind;
        int src;
        int num;
        int den;
        int cand;
        bit new_blk;
        bit extra_start;
    } case_t;

    // kind, source case, scale num/den, cand_id, new_block, start during busy
    case_t cases [N_CASES] = '{
        '{K_RAND,   0,  1, 1,  3, 1'b1, 1'b0},
        '{K_SCALED, 0,  1, 2,  5, 1'b0, 1'b1},
        '{K_SCALED, 1, -1, 1,  6, 1'b0, 1'b0},
        '{K_MIN,    0,  1, 1,  7, 1'b0, 1'b0},
        '{K_ZERO,   0,  1, 1,  9, 1'b0, 1'b0},
        '{K_ZERO,   0,  1, 1, 10, 1'b0, 1'b0},
        '{K_MIN,    0,  1, 1, 12, 1'b1, 1'b0},
        '{K_RAND,   0,  1, 1, 14, 1'b0, 1'b1},
        '{K_SCALED, 7,  1, 2,  2, 1'b0, 1'b0}
    };

    logic     clk;
    logic     rst_n;
    logic     row_wr;
    row_idx_t wr_row;
    ac_row_t  wr_ac;
    coef_t    wr_dc;
    logic     start;
    cand_t    cand_id;
    logic     new_block;
    logic     busy;
    cost_t    cost;
    logic     done;
    cost_t    best_cost;
    cand_t    best_id;
    logic     best_valid;

    coef_t ac_tab [N_CASES][ROWS][ROW_LEN];
    coef_t dc_tab [N_CASES][ROWS];

    int    mismatch_errs;
    int    fail_errs;
    bit    timed_out;
    cost_t exp_best;
    cand_t exp_id;
    logic  exp_valid;

    luma_cost_unit #(
        .ROWS (ROWS)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_wr     (row_wr),
        .wr_row     (wr_row),
        .wr_ac      (wr_ac),
        .wr_dc      (wr_dc),
        .start      (start),
        .cand_id    (cand_id),
        .new_block  (new_block),
        .busy       (busy),
        .cost       (cost),
        .done       (done),
        .best_cost  (best_cost),
        .best_id    (best_id),
        .best_valid (best_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_cost(input string what, input cost_t got, input cost_t exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_cand(input string what, input cand_t got, input cand_t exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // ------------------------------
    // Stimulus and reference model
    // ------------------------------
    // Column ROW_LEN stands for the DC coefficient
    task automatic fill_case(input int i);
        case_t e;
        int    v;
        int    src_v;
        e = cases[i];
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c <= ROW_LEN; c++) begin
                if (c < ROW_LEN) begin
                    src_v = int'(ac_tab[e.src][r][c]);
                end else begin
                    src_v = int'(dc_tab[e.src][r]);
                end
                case (e.kind)
                    K_RAND:  v = int'($urandom & 32'hffff) - 32768;
                    K_MIN:   v = -32768;
                    K_ZERO:  v = 0;
                    default: v = (src_v * e.num) / e.den;
                endcase
                if (c < ROW_LEN) begin
                    ac_tab[i][r][c] = coef_t'(v);
                end else begin
                    dc_tab[i][r] = coef_t'(v);
                end
            end
        end
    endtask

    function automatic cost_t block_energy(input int i);
        longint sum;
        longint v;
        sum = 0;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < ROW_LEN; c++) begin
                v = longint'(ac_tab[i][r][c]);
                sum += v * v;
            end
            v = longint'(dc_tab[i][r]);
            sum += v * v;
        end
        return cost_t'(sum);
    endfunction

    task automatic load_block(input int i);
        for (int r = 0; r < ROWS; r++) begin
            @(posedge clk);
            #1;
            row_wr = 1'b1;
            wr_row = row_idx_t'(r);
            wr_dc  = dc_tab[i][r];
            for (int c = 0; c < ROW_LEN; c++) begin
                wr_ac[c] = ac_tab[i][r][c];
            end
        end
        @(posedge clk);
        #1;
        row_wr = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (busy) begin
            fail_errs++;
            timed_out = 1'b1;
            $display("timeout: DUT still busy after %0d cycles", TIMEOUT);
        end
    endtask

    task automatic run_case(input int i);
        case_t e;
        cost_t exp_cost;
        int    n;
        e = cases[i];
        fill_case(i);
        exp_cost = block_energy(i);
        if (e.new_blk) begin
            @(posedge clk);
            #1;
            new_block = 1'b1;
            @(posedge clk);
            #1;
            new_block = 1'b0;
            check_flag("best_valid after new_block", best_valid, 1'b0);
            exp_valid = 1'b0;
        end
        load_block(i);
        wait_idle();
        if (timed_out) begin
            return;
        end
        start   = 1'b1;
        cand_id = cand_t'(e.cand);
        @(posedge clk);
        #1;
        start = 1'b0;
        check_flag("busy after start", busy, 1'b1);
        // Cycle count starts at 1 in the cycle after the start edge
        n = 1;
        while (!done && n < TIMEOUT) begin
            if (e.extra_start && n == 4) begin
                start   = 1'b1;
                cand_id = ~cand_t'(e.cand);
            end else begin
                start = 1'b0;
            end
            @(posedge clk);
            #1;
            n++;
        end
        start = 1'b0;
        if (!done) begin
            fail_errs++;
            timed_out = 1'b1;
            $display("timeout: no done within %0d cycles for case %0d", TIMEOUT, i);
            return;
        end
        if (n != ROWS + 2) begin
            mismatch_errs++;
            $display("mismatch at %0t: done in cycle %0d expected %0d", $time, n, ROWS + 2);
        end
        check_cost("cost", cost, exp_cost);
        if (e.kind == K_MIN) begin
            check_cost("cost of full-scale block", cost, cost_t'(ROWS * (ROW_LEN + 1)) << 30);
        end
        if (!exp_valid || exp_cost < exp_best) begin
            exp_best  = exp_cost;
            exp_id    = cand_t'(e.cand);
            exp_valid = 1'b1;
        end
        @(posedge clk);
        #1;
        check_flag("done after one cycle", done, 1'b0);
        check_cost("best_cost", best_cost, exp_best);
        check_cand("best_id", best_id, exp_id);
        check_flag("best_valid", best_valid, exp_valid);
        // No second done and no restart
        for (int k = 0; k < ROWS + 4; k++) begin
            @(posedge clk);
            #1;
            check_flag("done after pass", done, 1'b0);
            check_flag("busy after pass", busy, 1'b0);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        mismatch_errs = 0;
        fail_errs     = 0;
        timed_out     = 1'b0;
        exp_best      = '0;
        exp_id        = '0;
        exp_valid     = 1'b0;
        rst_n         = 1'b0;
        row_wr        = 1'b0;
        wr_row        = '0;
        wr_ac         = '0;
        wr_dc         = '0;
        start         = 1'b0;
        cand_id       = '0;
        new_block     = 1'b0;
        void'($urandom(32'hfd78));
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag("done after reset", done, 1'b0);
        check_flag("busy after reset", busy, 1'b0);
        check_flag("best_valid after reset", best_valid, 1'b0);
        check_cost("cost after reset", cost, '0);
        for (int i = 0; i < N_CASES; i++) begin
            if (timed_out) begin
                break;
            end
            run_case(i);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_errs, fail_errs);
        if (mismatch_errs == 0 && fail_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: luma_cost_unit.f
hw/luma_cost_pkg.sv
hw/coef_row_buffer.sv
hw/row_energy.sv
hw/block_cost_accum.sv
hw/best_cost_select.sv
hw/luma_cost_unit.sv
verification/luma_cost_properties.sv
verification/luma_cost_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the luma cost unit testbench with Verilator and runs it.
# Exits non-zero when the build fails, the run fails or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

TOP=luma_cost_unit_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f luma_cost_unit.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F '** FAIL **' "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
exit 0
